// File: rtl/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  byte_t;

    localparam int MEM_WORDS = 1024;   // 4 KB
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    typedef logic [MEM_IDX_W-1:0] mem_index_t;

    localparam word_t UART_TX_ADDR = 32'h0001_0000;   // outside RAM
    localparam word_t RESET_PC     = 32'h0000_0000;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_FENCE  = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_t;

    // values follow funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_size_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        alu_op_t   alu_op;
        logic      use_imm;       // operand b from imm
        logic      use_pc;        // operand a from pc, auipc
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        mem_size_t mem_size;
        logic      mem_unsigned;
        branch_t   branch;
        logic      jal;
        logic      jalr;
        logic      link;          // write back pc+4
    } ctrl_t;

    typedef struct packed {
        logic       we;
        mem_index_t addr;
        word_t      data;
    } prog_wr_t;

endpackage

// File: rtl/rv_decoder.sv
module rv_decoder
    import rv_pkg::*;
(
    input  word_t i_inst,
    output ctrl_t o_ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_t    op_alu;
    logic       reg_ok;
    logic       imm_ok;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                    i_inst[30:21], 1'b0};

    // funct7 legal only as zero or the sub/sra pattern, m extension falls out here
    assign reg_ok = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign imm_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                    (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                    1'b1;

    // shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  op_alu = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  op_alu = ALU_SLL;
            3'b010:  op_alu = ALU_SLT;
            3'b011:  op_alu = ALU_SLTU;
            3'b100:  op_alu = ALU_XOR;
            3'b101:  op_alu = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  op_alu = ALU_OR;
            default: op_alu = ALU_AND;
        endcase
    end

    always_comb begin
        o_ctrl          = '0;
        o_ctrl.rs1      = i_inst[19:15];
        o_ctrl.rs2      = i_inst[24:20];
        o_ctrl.rd       = i_inst[11:7];
        o_ctrl.alu_op   = ALU_ADD;
        o_ctrl.branch   = BR_NONE;
        o_ctrl.mem_size = MEM_WORD;

        case (opcode)
            OP_LUI: begin
                o_ctrl.imm       = imm_u;
                o_ctrl.alu_op    = ALU_PASS_B;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            OP_AUIPC: begin
                o_ctrl.imm       = imm_u;
                o_ctrl.use_pc    = 1'b1;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            OP_JAL: begin
                o_ctrl.imm       = imm_j;
                o_ctrl.jal       = 1'b1;
                o_ctrl.link      = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    o_ctrl.imm       = imm_i;
                    o_ctrl.jalr      = 1'b1;
                    o_ctrl.link      = 1'b1;
                    o_ctrl.reg_write = 1'b1;
                end
            end
            OP_BRANCH: begin
                o_ctrl.imm = imm_b;
                case (funct3)
                    3'b000:  o_ctrl.branch = BR_EQ;
                    3'b001:  o_ctrl.branch = BR_NE;
                    3'b100:  o_ctrl.branch = BR_LT;
                    3'b101:  o_ctrl.branch = BR_GE;
                    3'b110:  o_ctrl.branch = BR_LTU;
                    3'b111:  o_ctrl.branch = BR_GEU;
                    default: o_ctrl.branch = BR_NONE;
                endcase
            end
            OP_LOAD: begin
                if (funct3[1:0] != 2'b11 && funct3 != 3'b110) begin   // lb lh lw lbu lhu
                    o_ctrl.imm          = imm_i;
                    o_ctrl.mem_read     = 1'b1;
                    o_ctrl.reg_write    = 1'b1;
                    o_ctrl.mem_size     = mem_size_t'(funct3[1:0]);
                    o_ctrl.mem_unsigned = funct3[2];
                end
            end
            OP_STORE: begin
                if (!funct3[2] && funct3[1:0] != 2'b11) begin
                    o_ctrl.imm       = imm_s;
                    o_ctrl.mem_write = 1'b1;
                    o_ctrl.mem_size  = mem_size_t'(funct3[1:0]);
                end
            end
            OP_IMM: begin
                if (imm_ok) begin
                    o_ctrl.imm       = imm_i;   // shamt sits in imm[4:0]
                    o_ctrl.use_imm   = 1'b1;
                    o_ctrl.alu_op    = op_alu;
                    o_ctrl.reg_write = 1'b1;
                end
            end
            OP_REG: begin
                if (reg_ok) begin
                    o_ctrl.alu_op    = op_alu;
                    o_ctrl.reg_write = 1'b1;
                end
            end
            OP_FENCE, OP_SYSTEM: ;   // fence, ecall, ebreak run as nops
            default: ;
        endcase
    end

endmodule

// File: rtl/rv_regfile.sv
module rv_regfile
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    input  reg_addr_t i_rd,
    input  logic      i_we,
    input  word_t     i_wdata,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data
);

    word_t regs [1:31];   // x0 has no storage

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

    always_ff @(posedge clk) begin
        if (!reset && i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // a written register reads back its new value in the next cycle
    a_write_readback: assert property (@(posedge clk)
        (!reset && i_we && i_rd != '0) |=>
            (i_rs1 != $past(i_rd) || o_rs1_data == $past(i_wdata)))
        else $error("register written last cycle read back a different value");

endmodule

// File: rtl/rv_alu.sv
module rv_alu
    import rv_pkg::*;
(
    input  ctrl_t i_ctrl,
    input  word_t i_pc,
    input  word_t i_rs1_data,
    input  word_t i_rs2_data,
    output word_t o_result,
    output word_t o_addr,
    output logic  o_branch_taken
);

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    logic       eq;
    logic       lt;
    logic       ltu;

    assign op_a  = i_ctrl.use_pc ? i_pc : i_rs1_data;
    assign op_b  = i_ctrl.use_imm ? i_ctrl.imm : i_rs2_data;
    assign shamt = op_b[4:0];

    // branches have both operands from registers, so one comparator serves slt too
    assign eq  = (op_a == op_b);
    assign lt  = ($signed(op_a) < $signed(op_b));
    assign ltu = (op_a < op_b);

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD:    o_result = op_a + op_b;
            ALU_SUB:    o_result = op_a - op_b;
            ALU_AND:    o_result = op_a & op_b;
            ALU_OR:     o_result = op_a | op_b;
            ALU_XOR:    o_result = op_a ^ op_b;
            ALU_SLL:    o_result = op_a << shamt;
            ALU_SRL:    o_result = op_a >> shamt;
            ALU_SRA:    o_result = $signed(op_a) >>> shamt;
            ALU_SLT:    o_result = {31'b0, lt};
            ALU_SLTU:   o_result = {31'b0, ltu};
            ALU_PASS_B: o_result = op_b;
            default:    o_result = '0;
        endcase
    end

    always_comb begin
        case (i_ctrl.branch)
            BR_EQ:   o_branch_taken = eq;
            BR_NE:   o_branch_taken = !eq;
            BR_LT:   o_branch_taken = lt;
            BR_GE:   o_branch_taken = !lt;
            BR_LTU:  o_branch_taken = ltu;
            BR_GEU:  o_branch_taken = !ltu;
            default: o_branch_taken = 1'b0;
        endcase
    end

    assign o_addr = i_rs1_data + i_ctrl.imm;   // loads, stores, jalr

endmodule

// File: rtl/rv_mem.sv
module rv_mem
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  prog_wr_t i_prog,
    input  word_t    i_pc,
    output word_t    o_inst,
    input  ctrl_t    i_ctrl,
    input  word_t    i_addr,
    input  word_t    i_wdata,
    output word_t    o_load_data,
    output logic     o_uart_en,
    output byte_t    o_uart_data
);

    word_t      mem [MEM_WORDS];
    mem_index_t data_idx;
    logic       in_ram;
    logic       is_uart;
    logic       store_en;
    logic [3:0] byte_en;
    word_t      st_lanes;
    word_t      rd_word;
    word_t      rd_shift;

    assign o_inst = mem[i_pc[MEM_IDX_W+1:2]];

    assign data_idx = i_addr[MEM_IDX_W+1:2];
    assign in_ram   = (i_addr[31:MEM_IDX_W+2] == '0);
    assign is_uart  = (i_addr == UART_TX_ADDR);
    assign store_en = i_ctrl.mem_write && !reset;   // fetch during reset is not executed

    // replicate the data over all lanes, byte enables pick the target
    always_comb begin
        case (i_ctrl.mem_size)
            MEM_BYTE: begin
                st_lanes = {4{i_wdata[7:0]}};
                byte_en  = 4'b0001 << i_addr[1:0];
            end
            MEM_HALF: begin
                st_lanes = {2{i_wdata[15:0]}};
                byte_en  = 4'b0011 << {i_addr[1], 1'b0};
            end
            default: begin
                st_lanes = i_wdata;
                byte_en  = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            if (i_prog.we) mem[i_prog.addr] <= i_prog.data;   // program load
        end else if (store_en && in_ram) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) mem[data_idx][8*i +: 8] <= st_lanes[8*i +: 8];
            end
        end
    end

    assign rd_word  = in_ram ? mem[data_idx] : '0;
    assign rd_shift = rd_word >> {i_addr[1:0], 3'b000};

    always_comb begin
        case (i_ctrl.mem_size)
            MEM_BYTE: o_load_data = i_ctrl.mem_unsigned ? {24'b0, rd_shift[7:0]} :
                                    {{24{rd_shift[7]}}, rd_shift[7:0]};
            MEM_HALF: o_load_data = i_ctrl.mem_unsigned ? {16'b0, rd_shift[15:0]} :
                                    {{16{rd_shift[15]}}, rd_shift[15:0]};
            default:  o_load_data = rd_word;
        endcase
    end

    // tx strobe only on sb to the uart register
    assign o_uart_en   = store_en && is_uart && (i_ctrl.mem_size == MEM_BYTE);
    assign o_uart_data = i_wdata[7:0];

    a_prog_in_reset: assert property (@(posedge clk) i_prog.we |-> reset)
        else $error("program write outside reset");

endmodule

// File: rtl/rv_core.sv
module rv_core
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  prog_wr_t i_prog,
    output logic     o_uart_en,
    output byte_t    o_uart_data
);

    word_t pc;
    word_t pc_plus4;
    word_t next_pc;
    word_t inst;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;
    word_t eff_addr;
    word_t load_data;
    word_t wb_data;
    ctrl_t ctrl;
    logic  branch_taken;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (ctrl.jalr) begin
            next_pc = {eff_addr[31:1], 1'b0};
        end else if (ctrl.jal || branch_taken) begin
            next_pc = pc + ctrl.imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        if (ctrl.mem_read) wb_data = load_data;
        else if (ctrl.link) wb_data = pc_plus4;
        else wb_data = alu_result;
    end

    always_ff @(posedge clk) begin
        if (reset) pc <= RESET_PC;
        else pc <= next_pc;
    end

    rv_decoder u_decoder (
        .i_inst (inst),
        .o_ctrl (ctrl)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .i_rs1      (ctrl.rs1),
        .i_rs2      (ctrl.rs2),
        .i_rd       (ctrl.rd),
        .i_we       (ctrl.reg_write),
        .i_wdata    (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_alu u_alu (
        .i_ctrl         (ctrl),
        .i_pc           (pc),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .o_result       (alu_result),
        .o_addr         (eff_addr),
        .o_branch_taken (branch_taken)
    );

    rv_mem u_mem (
        .clk         (clk),
        .reset       (reset),
        .i_prog      (i_prog),
        .i_pc        (pc),
        .o_inst      (inst),
        .i_ctrl      (ctrl),
        .i_addr      (eff_addr),
        .i_wdata     (rs2_data),
        .o_load_data (load_data),
        .o_uart_en   (o_uart_en),
        .o_uart_data (o_uart_data)
    );

    // misaligned jump or branch target in the program
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc misaligned: %h", pc);

endmodule

// File: testbench/tb_rv_core.sv
module tb_rv_core
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam string TRACE_FILE = "testbench/rv_trace.txt";

    logic     clk = 1'b0;
    logic     reset = 1'b1;
    prog_wr_t i_prog = '0;
    logic     o_uart_en;
    byte_t    o_uart_data;

    mem_index_t prog_addrs [$];
    word_t      prog_data [$];
    byte_t      exp_bytes [$];
    byte_t      marker;
    int         cycle_budget = 0;
    int         reset_cycles;
    int         rx_count = 0;
    longint     watchdog_ns;
    logic       trace_ready = 1'b0;
    logic       finished = 1'b0;

    rv_core u_rv_core (
        .clk         (clk),
        .reset       (reset),
        .i_prog      (i_prog),
        .o_uart_en   (o_uart_en),
        .o_uart_data (o_uart_data)
    );

    always #4 clk = ~clk;   // 8 ns period

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic read_trace();
        int          fd;
        int          code;
        byte_t       kind;
        int unsigned addr;
        word_t       value;
        string       rest;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) fail_run("cannot open the trace file testbench/rv_trace.txt");
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) break;
            case (kind)
                "P": begin
                    code = $fscanf(fd, "%h %h", addr, value);
                    prog_addrs.push_back(mem_index_t'(addr));
                    prog_data.push_back(value);
                end
                "U": begin
                    code = $fscanf(fd, "%h", value);
                    exp_bytes.push_back(byte_t'(value));
                end
                "C": code = $fscanf(fd, "%d", cycle_budget);
                "#": ;   // comment line
                default: fail_run($sformatf("unknown line kind '%c' in the trace file", kind));
            endcase
            code = $fgets(rest, fd);   // rest of the line is annotation
        end
        $fclose(fd);
        if (prog_data.size() == 0 || exp_bytes.size() == 0 || cycle_budget <= 0) begin
            fail_run("trace file holds no program, no expected bytes or no cycle budget");
        end
    endtask

    // one word per edge while reset is held
    task automatic load_program();
        foreach (prog_data[i]) begin
            @(posedge clk);
            i_prog <= '{we: 1'b1, addr: prog_addrs[i], data: prog_data[i]};
        end
        repeat (reset_cycles - prog_data.size()) @(posedge clk);
        @(posedge clk);
        reset  <= 1'b0;
        i_prog <= '0;
    endtask

    task automatic check_uart_byte(input byte_t got);
        if (got !== exp_bytes[rx_count]) begin
            fail_run($sformatf("FAILED @%0t: uart byte %0d is %h, expected %h",
                               $time, rx_count, got, exp_bytes[rx_count]));
        end
    endtask

    task automatic check_count(input int got, input int expected);
        if (got != expected) begin
            fail_run($sformatf("FAILED @%0t: %0d uart bytes received, expected %0d",
                               $time, got, expected));
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (reset && o_uart_en === 1'b1) begin
            fail_run("the uart strobe went high while reset was held");
        end else if (!reset && o_uart_en === 1'b1 && !finished) begin
            if (o_uart_data == marker) begin   // end of program
                check_count(rx_count + 1, exp_bytes.size());
            end
            check_uart_byte(o_uart_data);
            rx_count = rx_count + 1;
            if (o_uart_data == marker) begin
                finished = 1'b1;
            end
        end
    end

    initial begin
        wait (trace_ready);
        #(watchdog_ns);
        fail_run($sformatf("timeout: the program did not send its final byte within %0d ns",
                           watchdog_ns));
    end

    initial begin
        read_trace();
        marker       = exp_bytes[$];
        reset_cycles = (prog_data.size() + 1 > 10) ? prog_data.size() + 1 : 10;
        watchdog_ns  = 8 * (longint'(reset_cycles) + longint'(cycle_budget) + 2);
        trace_ready  = 1'b1;
        load_program();
        wait (finished);
        $display("Test OK");
        $finish;
    end

endmodule

// File: all.f
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_mem.sv
rtl/rv_core.sv
testbench/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator; exit status follows the run
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_rv_core -o sim_rv_core

./obj_dir/sim_rv_core

// File: testbench/rv_trace.txt
# P <word index> <instruction word>, U <expected uart byte>, C <cycle budget after reset>
# x31 holds the uart address, every emit is sb xN,0(x31)
P 000 00010fb7  lui x31,0x10
P 001 06400093  addi x1,x0,100
P 002 ff900113  addi x2,x0,-7
P 003 00300293  addi x5,x0,3
P 004 002081b3  add
P 005 003f8023
P 006 402081b3  sub
P 007 003f8023
P 008 0020f1b3  and
P 009 003f8023
P 00a 0020e1b3  or
P 00b 003f8023
P 00c 0020c1b3  xor
P 00d 003f8023
P 00e 005091b3  sll
P 00f 003f8023
P 010 0050d1b3  srl
P 011 003f8023
P 012 405151b3  sra
P 013 003f8023
P 014 001121b3  slt
P 015 003f8023
P 016 001131b3  sltu
P 017 003f8023
P 018 00209193  slli
P 019 003f8023
P 01a 40115193  srai
P 01b 003f8023
P 01c 01c15193  srli
P 01d 003f8023
P 01e fff0b193  sltiu
P 01f 003f8023
P 020 fff0a193  slti
P 021 003f8023
P 022 00f0c193  xori
P 023 003f8023
P 024 03c17193  andi
P 025 003f8023
P 026 0010e193  ori
P 027 003f8023
P 028 123451b7  lui x3,0x12345
P 029 00c1d193  srli x3,x3,12
P 02a 003f8023
P 02b 00000197  auipc x3,0
P 02c 003f8023
P 02d 0b100513  x10..x15 not-taken bytes, x16 wrong-path byte
P 02e 0b200593
P 02f 0b300613
P 030 0b400693
P 031 0b500713
P 032 0b600793
P 033 0ee00813
P 034 00108463  beq taken
P 035 010f8023
P 036 00208463  beq not taken
P 037 00af8023
P 038 00209463  bne taken
P 039 010f8023
P 03a 00109463  bne not taken
P 03b 00bf8023
P 03c 00114463  blt taken
P 03d 010f8023
P 03e 0020c463  blt not taken
P 03f 00cf8023
P 040 0020d463  bge taken
P 041 010f8023
P 042 00115463  bge not taken
P 043 00df8023
P 044 0020e463  bltu taken
P 045 010f8023
P 046 00116463  bltu not taken
P 047 00ef8023
P 048 00117463  bgeu taken
P 049 010f8023
P 04a 0020f463  bgeu not taken
P 04b 00ff8023
P 04c 008008ef  jal x17,+8
P 04d 010f8023
P 04e 011f8023
P 04f 00000917  auipc x18,0
P 050 011909e7  jalr x19,17(x18)
P 051 010f8023
P 052 010f8023
P 053 013f8023
P 054 40000a13  addi x20,x0,0x400
P 055 81828ab7  lui x21,0x81828
P 056 384a8a93  addi x21,x21,0x384
P 057 edd00b13  addi x22,x0,-0x123
P 058 015a2023  sw x21,0(x20)
P 059 016a1123  sh x22,2(x20)
P 05a 001a00a3  sb x1,1(x20)
P 05b 001a0183  lb 1
P 05c 003f8023
P 05d 0181d213  srli x4,x3,24
P 05e 004f8023
P 05f 003a0183  lb 3
P 060 003f8023
P 061 0181d213
P 062 004f8023
P 063 000a4183  lbu 0
P 064 003f8023
P 065 0181d213
P 066 004f8023
P 067 002a4183  lbu 2
P 068 003f8023
P 069 0181d213
P 06a 004f8023
P 06b 002a1183  lh 2
P 06c 003f8023
P 06d 0181d213
P 06e 004f8023
P 06f 000a5183  lhu 0
P 070 003f8023
P 071 0081d213  srli x4,x3,8
P 072 004f8023
P 073 000a2183  lw 0
P 074 003f8023
P 075 0181d213
P 076 004f8023
P 077 05500013  addi x0,x0,0x55
P 078 000f8023  sb x0
P 079 07e00193  final marker
P 07a 003f8023
P 07b 0000006f  jal x0,0
U 5d
U 6b
U 60
U fd
U 9d
U 20
U 0c
U ff
U 01
U 00
U 90
U fc
U 0f
U 01
U 00
U 6b
U 38
U 65
U 45
U ac
U b1
U b2
U b3
U b4
U b5
U b6
U 34
U 44
U 64
U 00
U fe
U ff
U 84
U 00
U dd
U 00
U dd
U ff
U 84
U 64
U 84
U fe
U 00
U 7e
C 200
